//--- run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass message
verilator --binary --assert -Wno-fatal --top-module tb_top -f vlog.f -o tb_sim \
    && ./obj_dir/tb_sim | tee /dev/stderr | grep -q "Finished with no errors" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

//--- sim/glue_chk.sv
module glue_chk (
    input logic clk_sys,
    input logic reset,
    input logic ce_cpu,
    input logic ce_cpu_n,
    input logic ce_cpu2x,
    input logic sdram_oe,
    input logic sdram_we,
    input logic vga_hs
);
    timeunit 1ns;
    timeprecision 1ps;

    // Number of failed assertions
    int fail_count = 0;

    // Double-speed enable only on one of the two CPU phases
    ce2x_on_phase: assert property (@(posedge clk_sys) disable iff (reset)
        ce_cpu2x |-> (ce_cpu || ce_cpu_n))
        else begin
            $error("ce_cpu2x high without ce_cpu or ce_cpu_n");
            fail_count++;
        end

    // SDRAM request is either a read or a write
    oe_we_exclusive: assert property (@(posedge clk_sys) disable iff (reset)
        !(sdram_oe && sdram_we))
        else begin
            $error("sdram_oe and sdram_we high together");
            fail_count++;
        end

    // HSync pulse is one cycle wide
    hs_single_cycle: assert property (@(posedge clk_sys) disable iff (reset)
        !vga_hs |=> vga_hs)
        else begin
            $error("vga_hs low for two cycles in a row");
            fail_count++;
        end

endmodule

bind gb_glue_top glue_chk u_glue_chk (
    .clk_sys  (clk_sys),
    .reset    (reset),
    .ce_cpu   (ce_cpu),
    .ce_cpu_n (ce_cpu_n),
    .ce_cpu2x (ce_cpu2x),
    .sdram_oe (sdram_oe),
    .sdram_we (sdram_we),
    .vga_hs   (vga_hs)
);

//--- sim/tb_checker.sv
module tb_checker
    import gb_glue_pkg::*;
(
    input logic        clk_sys,
    input logic        reset,
    input logic [2:0]  phase,
    input logic        ce_cpu, ce_cpu_n, ce_cpu2x, ce_32k,
    input logic        ioctl_download, ioctl_wr,
    input logic [7:0]  ioctl_index,
    input logic [24:0] ioctl_addr,
    input logic [15:0] ioctl_dout, sdram_do, sdram_di,
    input logic [22:0] mbc_addr,
    input logic        cart_rd, cram_rd, cart_download, sdram_oe, sdram_we,
    input logic [23:0] sdram_addr,
    input logic [1:0]  sdram_ds, lcd_data_gb,
    input logic [7:0]  rom_byte, vga_r, vga_g, vga_b,
    input lcd_mode_e   lcd_mode,
    input logic [14:0] lcd_data,
    input logic        lcd_vsync, is_gbc_game,
    input logic        vga_hs, vga_vs, vga_hb, vga_vb,
    output int         check_total,
    output int         error_total
);
    timeunit 1ns;
    timeprecision 1ps;

    // Per-test tallies, index is the test number
    int test_checks [0:5] = '{default: 0};
    int test_errors [0:5] = '{default: 0};
    int n_checks = 0;
    int n_errors = 0;
    int cur = 1;
    logic [2:0] last_phase = 3'd0;

    // Enable gap tracking, cycles counted out of reset
    int cyc = 0;
    int last_cpu = 0;
    int last_32k = 0;
    int n_since_cpu = 0;
    int cpu_pulses = 0;
    int rtc_pulses = 0;
    bit cpu_seen = 1'b0;
    bit rtc_seen = 1'b0;

    // HSync model state
    logic exp_hs = 1'b1;
    logic last_hb = 1'b0;

    assign check_total = n_checks;
    assign error_total = n_errors;

    task automatic compare(input string what, input logic [31:0] got,
                           input logic [31:0] exp);
        test_checks[cur]++;
        n_checks++;
        if (got !== exp) begin
            test_errors[cur]++;
            n_errors++;
            $display("[ERROR] %0t: %s is %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    function automatic string test_name(input int idx);
        case (idx)
            1: return "clock enables";
            2: return "ROM download";
            3: return "cartridge play";
            default: return "LCD to VGA";
        endcase
    endfunction

    // ====================
    // Enable timing
    // ====================

    task automatic track_enables();
        if (ce_cpu) begin
            if (cpu_seen) begin
                compare("ce_cpu gap", 32'(cyc - last_cpu), 32'd16);
                compare("ce_cpu_n pulses per period", 32'(n_since_cpu), 32'd1);
            end
            cpu_seen = 1'b1;
            last_cpu = cyc;
            n_since_cpu = 0;
            cpu_pulses++;
        end
        if (ce_cpu_n) begin
            n_since_cpu++;
            // Half a period after ce_cpu
            if (cpu_seen) compare("ce_cpu_n offset", 32'(cyc - last_cpu), 32'd8);
        end
        if (ce_32k) begin
            if (rtc_seen) compare("ce_32k gap", 32'(cyc - last_32k), 32'd2048);
            rtc_seen = 1'b1;
            last_32k = cyc;
            rtc_pulses++;
        end
    endtask

    task automatic check_pulse_counts();
        // About 262 CPU pulses and two RTC pulses fit in 4200 cycles
        if (cpu_pulses < 260 || rtc_pulses < 2) begin
            test_errors[1]++;
            n_errors++;
            $display("Enable test saw too few pulses: %0d ce_cpu, %0d ce_32k",
                     cpu_pulses, rtc_pulses);
        end
    endtask

    // ====================
    // ROM port model
    // ====================

    task automatic check_rom_port();
        logic is_cart;
        logic dl;
        is_cart = (ioctl_index[5:0] == 6'h01) || (ioctl_index == 8'h00)
                  || (ioctl_index == 8'h80);
        dl = ioctl_download && is_cart;
        compare("cart_download", 32'(cart_download), 32'(dl));
        if (dl) begin
            // Loader writes whole words
            compare("sdram_addr", 32'(sdram_addr), 32'(ioctl_addr[24:1]));
            compare("sdram_di", 32'(sdram_di), 32'(ioctl_dout));
            compare("sdram_ds", 32'(sdram_ds), 32'd3);
            compare("sdram_oe", 32'(sdram_oe), 32'd0);
            compare("sdram_we", 32'(sdram_we), 32'(ioctl_wr));
        end else begin
            // Mapper byte read
            compare("sdram_addr", 32'(sdram_addr), {10'd0, mbc_addr[22:1]});
            compare("sdram_di", 32'(sdram_di), 32'd0);
            compare("sdram_ds", 32'(sdram_ds), {30'd0, mbc_addr[0], !mbc_addr[0]});
            compare("sdram_oe", 32'(sdram_oe), 32'(cart_rd && !cram_rd));
            compare("sdram_we", 32'(sdram_we), 32'd0);
        end
        compare("rom_byte", 32'(rom_byte),
                32'(mbc_addr[0] ? sdram_do[15:8] : sdram_do[7:0]));
    endtask

    // ====================
    // Video model
    // ====================

    task automatic check_video();
        logic [7:0] grey;
        case (lcd_data_gb)
            2'd0: grey = 8'hff;
            2'd1: grey = 8'haa;
            2'd2: grey = 8'h55;
            default: grey = 8'h00;
        endcase
        if (is_gbc_game) begin
            // Top three bits repeated below each 5-bit field
            compare("vga_r", 32'(vga_r), 32'({lcd_data[14:10], lcd_data[14:12]}));
            compare("vga_g", 32'(vga_g), 32'({lcd_data[9:5], lcd_data[9:7]}));
            compare("vga_b", 32'(vga_b), 32'({lcd_data[4:0], lcd_data[4:2]}));
        end else begin
            compare("vga_r", 32'(vga_r), 32'(grey));
            compare("vga_g", 32'(vga_g), 32'(grey));
            compare("vga_b", 32'(vga_b), 32'(grey));
        end
        compare("vga_hb", 32'(vga_hb), 32'(lcd_mode == lcd_hblank));
        compare("vga_vb", 32'(vga_vb), 32'(lcd_mode == lcd_vblank));
        compare("vga_vs", 32'(vga_vs), 32'(!lcd_vsync));
    endtask

    // ====================
    // Sampling
    // ====================

    // Falling edge, all inputs and outputs settled
    always @(negedge clk_sys) begin
        if (phase != last_phase) begin
            if (last_phase == 3'd1) check_pulse_counts();
            if (last_phase >= 3'd1 && last_phase <= 3'd4) begin
                $display("Test %0d %s: %0d checks, %0d errors, %s", last_phase,
                         test_name(int'(last_phase)), test_checks[last_phase],
                         test_errors[last_phase],
                         (test_errors[last_phase] == 0) ? "PASS" : "FAIL");
            end
            last_phase = phase;
        end
        // Reset cycles count toward the enable test
        cur = (phase == 3'd0) ? 1 : int'(phase);
        if (phase != 3'd5) begin
            if (reset) begin
                compare("ce_cpu in reset", 32'(ce_cpu), 32'd0);
                compare("ce_cpu_n in reset", 32'(ce_cpu_n), 32'd0);
                compare("ce_cpu2x in reset", 32'(ce_cpu2x), 32'd0);
                compare("ce_32k in reset", 32'(ce_32k), 32'd0);
            end else begin
                cyc++;
                compare("ce_cpu2x", 32'(ce_cpu2x), 32'(ce_cpu | ce_cpu_n));
                compare("sdram_oe with sdram_we", 32'(sdram_oe & sdram_we), 32'd0);
                if (phase == 3'd1) track_enables();
                if (phase == 3'd2 || phase == 3'd3) check_rom_port();
                if (phase == 3'd4) check_video();
            end
            compare("vga_hs", 32'(vga_hs), 32'(exp_hs));
        end
        // Next HSync value, low only on the first hblank cycle
        if (reset) begin
            exp_hs = 1'b1;
            last_hb = 1'b0;
        end else begin
            exp_hs = !((lcd_mode == lcd_hblank) && !last_hb);
            last_hb = (lcd_mode == lcd_hblank);
        end
    end

endmodule

//--- sim/tb_top.sv
module tb_top
    import gb_glue_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    logic clk_sys;
    logic reset;
    logic [2:0] phase;
    int cycles;
    int check_total;
    int error_total;

    // DUT inputs
    logic ioctl_download, ioctl_wr;
    logic [7:0] ioctl_index;
    logic [24:0] ioctl_addr;
    logic [15:0] ioctl_dout, sdram_do;
    logic [22:0] mbc_addr;
    logic cart_rd, cram_rd;
    lcd_mode_e lcd_mode;
    logic [14:0] lcd_data;
    logic [1:0] lcd_data_gb;
    logic lcd_vsync, is_gbc_game;

    // DUT outputs
    logic ce_cpu, ce_cpu_n, ce_cpu2x, ce_32k;
    logic cart_download, sdram_oe, sdram_we;
    logic [23:0] sdram_addr;
    logic [15:0] sdram_di;
    logic [1:0] sdram_ds;
    logic [7:0] rom_byte, vga_r, vga_g, vga_b;
    logic vga_hs, vga_vs, vga_hb, vga_vb;

    gb_glue_top dut (.*);

    tb_checker u_checker (.*);

    // 4 ns clock
    always #2 clk_sys = ~clk_sys;

    // ====================
    // Stimulus tasks
    // ====================

    task automatic drive_download();
        int pick;
        pick = int'($urandom_range(0, 7));
        ioctl_download <= ($urandom_range(0, 7) != 0);
        // Bias toward the three cartridge codes
        case (pick)
            0: ioctl_index <= 8'h00;
            1: ioctl_index <= 8'h80;
            2, 3: ioctl_index <= {2'($urandom), 6'h01};
            default: ioctl_index <= 8'($urandom);
        endcase
        ioctl_wr <= 1'($urandom);
        ioctl_addr <= 25'($urandom);
        ioctl_dout <= 16'($urandom);
        mbc_addr <= 23'($urandom);
        cart_rd <= 1'($urandom);
        cram_rd <= 1'($urandom);
        sdram_do <= 16'($urandom);
    endtask

    task automatic drive_play();
        ioctl_download <= 1'b0;
        mbc_addr <= 23'($urandom);
        cart_rd <= 1'($urandom);
        cram_rd <= 1'($urandom);
        sdram_do <= 16'($urandom);
    endtask

    task automatic drive_video();
        // Hold the mode for a few cycles so hblank runs form
        if ($urandom_range(0, 3) == 0) lcd_mode <= lcd_mode_e'(2'($urandom_range(0, 3)));
        lcd_vsync <= ($urandom_range(0, 15) == 0);
        is_gbc_game <= 1'($urandom);
        lcd_data <= 15'($urandom);
        lcd_data_gb <= 2'($urandom);
    endtask

    // ====================
    // Test sequence
    // ====================

    initial begin
        void'($urandom(32'h6a487996));
        clk_sys = 1'b0;
        reset = 1'b1;
        phase = 3'd0;
        ioctl_download = 1'b0;
        ioctl_wr = 1'b0;
        ioctl_index = 8'h00;
        ioctl_addr = '0;
        ioctl_dout = '0;
        mbc_addr = '0;
        cart_rd = 1'b0;
        cram_rd = 1'b0;
        sdram_do = '0;
        lcd_mode = lcd_pixel_xfer;
        lcd_data = '0;
        lcd_data_gb = 2'd0;
        lcd_vsync = 1'b0;
        is_gbc_game = 1'b0;
        repeat (2) @(posedge clk_sys);
        reset <= 1'b0;
        phase <= 3'd1;
        repeat (4200) @(posedge clk_sys);
        phase <= 3'd2;
        repeat (1000) begin
            drive_download();
            @(posedge clk_sys);
        end
        phase <= 3'd3;
        repeat (1000) begin
            drive_play();
            @(posedge clk_sys);
        end
        phase <= 3'd4;
        repeat (2000) begin
            drive_video();
            @(posedge clk_sys);
        end
        phase <= 3'd5;
        repeat (3) @(posedge clk_sys);
        $display("Closing counts: %0d checks, %0d errors, %0d assertion failures",
                 check_total, error_total, dut.u_glue_chk.fail_count);
        if (error_total == 0 && dut.u_glue_chk.fail_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    // Limit sits well above the 8205 cycles of reset and tests
    initial cycles = 0;
    always @(posedge clk_sys) begin
        cycles <= cycles + 1;
        if (cycles >= 10000) begin
            $display("Timeout: the run did not finish within 10000 cycles");
            $display("Finished with errors");
            $finish;
        end
    end

endmodule

//--- src/clock_enables.sv
module clock_enables
    import gb_glue_pkg::*;
(
    input  logic clk_sys,
    input  logic reset,
    output logic ce_cpu,
    output logic ce_cpu_n,
    output logic ce_cpu2x,
    output logic ce_32k
);

    // Free-running CPU phase counter
    logic [ce_div_bits-1:0] cpu_div;
    logic [ce_div_bits-1:0] cpu_div_next;

    // Slow counter for the RTC tick
    logic [ce_32k_bits-1:0] rtc_div;
    logic [ce_32k_bits-1:0] rtc_div_next;

    // Phase matches on the next count
    logic hit_cpu;
    logic hit_cpu_n;
    logic hit_32k;

    // ====================
    // Divider arithmetic
    // ====================

    assign cpu_div_next = cpu_div + ce_div_bits'(1);
    assign rtc_div_next = rtc_div + ce_32k_bits'(1);

    // Decode from the next value so each enable lands on the
    // same edge as the count it belongs to
    assign hit_cpu = (cpu_div_next == ce_cpu_phase);
    assign hit_cpu_n = (cpu_div_next == ce_cpu_n_phase);
    assign hit_32k = (rtc_div_next == ce_32k_phase);

    // ====================
    // CPU enables
    // ====================

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            cpu_div <= '0;
            ce_cpu <= 1'b0;
            ce_cpu_n <= 1'b0;
            ce_cpu2x <= 1'b0;
        end else begin
            cpu_div <= cpu_div_next;
            // Normal speed, one cycle in sixteen
            ce_cpu <= hit_cpu;
            // Same rate, opposite half of the period
            ce_cpu_n <= hit_cpu_n;
            // Double speed fires on both phases
            ce_cpu2x <= hit_cpu | hit_cpu_n;
        end
    end

    // ====================
    // RTC enable
    // ====================

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            rtc_div <= '0;
            ce_32k <= 1'b0;
        end else begin
            rtc_div <= rtc_div_next;
            // One cycle per wrap of the slow counter
            ce_32k <= hit_32k;
        end
    end

endmodule

//--- src/gb_glue_pkg.sv
package gb_glue_pkg;

    // ====================
    // Clock divider
    // ====================

    // CPU enable divider width, one pulse every 16 clk_sys cycles
    localparam int ce_div_bits = 4;

    // RTC enable divider width, one pulse every 2048 cycles
    localparam int ce_32k_bits = 11;

    // Divider count at which ce_cpu fires
    localparam logic [ce_div_bits-1:0] ce_cpu_phase = '0;

    // Opposite phase, half a period later
    localparam logic [ce_div_bits-1:0] ce_cpu_n_phase = {1'b1, {(ce_div_bits - 1){1'b0}}};

    // Divider count at which ce_32k fires
    localparam logic [ce_32k_bits-1:0] ce_32k_phase = '0;

    // ====================
    // Bus widths
    // ====================

    // Download byte address from the loader
    localparam int ioctl_addr_w = 25;

    // SDRAM word address
    localparam int sdram_addr_w = 24;

    // Mapper byte address
    localparam int mbc_addr_w = 23;

    // Packed RGB555 pixel, R in the top field
    localparam int rgb555_w = 15;

    // One VGA colour channel
    localparam int vga_chan_w = 8;

    // ====================
    // Download index codes
    // ====================

    // Compared on the low six bits only
    localparam logic [5:0] cart_index_low = 6'h01;

    // These two are compared on all eight bits
    localparam logic [7:0] cart_index_boot = 8'h00;
    localparam logic [7:0] cart_index_alt = 8'h80;

    // ====================
    // Monochrome palette
    // ====================

    localparam logic [vga_chan_w-1:0] shade_white = 8'hff;
    localparam logic [vga_chan_w-1:0] shade_light = 8'haa;
    localparam logic [vga_chan_w-1:0] shade_dark = 8'h55;
    localparam logic [vga_chan_w-1:0] shade_black = 8'h00;

    // LCD controller mode as reported by the PPU
    typedef enum logic [1:0] {
        lcd_hblank     = 2'd0,
        lcd_vblank     = 2'd1,
        lcd_oam_scan   = 2'd2,
        lcd_pixel_xfer = 2'd3
    } lcd_mode_e;

endpackage

//--- src/gb_glue_top.sv
module gb_glue_top
    import gb_glue_pkg::*;
(
    input  logic                    clk_sys,
    input  logic                    reset,

    // Clock enables for the external core
    output logic                    ce_cpu,
    output logic                    ce_cpu_n,
    output logic                    ce_cpu2x,
    output logic                    ce_32k,

    // ROM download from the loader
    input  logic                    ioctl_download,
    input  logic                    ioctl_wr,
    input  logic [7:0]              ioctl_index,
    input  logic [ioctl_addr_w-1:0] ioctl_addr,
    input  logic [15:0]             ioctl_dout,

    // Mapper requests during play
    input  logic [mbc_addr_w-1:0]   mbc_addr,
    input  logic                    cart_rd,
    input  logic                    cram_rd,

    // SDRAM request and return data
    input  logic [15:0]             sdram_do,
    output logic                    cart_download,
    output logic [sdram_addr_w-1:0] sdram_addr,
    output logic [15:0]             sdram_di,
    output logic [1:0]              sdram_ds,
    output logic                    sdram_oe,
    output logic                    sdram_we,
    output logic [7:0]              rom_byte,

    // LCD stream from the PPU
    input  lcd_mode_e               lcd_mode,
    input  logic [rgb555_w-1:0]     lcd_data,
    input  logic [1:0]              lcd_data_gb,
    input  logic                    lcd_vsync,
    input  logic                    is_gbc_game,

    // VGA out
    output logic [vga_chan_w-1:0]   vga_r,
    output logic [vga_chan_w-1:0]   vga_g,
    output logic [vga_chan_w-1:0]   vga_b,
    output logic                    vga_hs,
    output logic                    vga_vs,
    output logic                    vga_hb,
    output logic                    vga_vb
);

    // ====================
    // Input side
    // ====================

    // CPU and RTC enables, all derived from clk_sys
    clock_enables u_clk_en (
        .clk_sys  (clk_sys),
        .reset    (reset),
        .ce_cpu   (ce_cpu),
        .ce_cpu_n (ce_cpu_n),
        .ce_cpu2x (ce_cpu2x),
        .ce_32k   (ce_32k)
    );

    // ====================
    // ROM port
    // ====================

    // Download or play decides who owns the SDRAM request
    rom_port_mux u_rom_port (
        .ioctl_download (ioctl_download),
        .ioctl_wr       (ioctl_wr),
        .ioctl_index    (ioctl_index),
        .ioctl_addr     (ioctl_addr),
        .ioctl_dout     (ioctl_dout),
        .mbc_addr       (mbc_addr),
        .cart_rd        (cart_rd),
        .cram_rd        (cram_rd),
        .sdram_do       (sdram_do),
        .cart_download  (cart_download),
        .sdram_addr     (sdram_addr),
        .sdram_di       (sdram_di),
        .sdram_ds       (sdram_ds),
        .sdram_oe       (sdram_oe),
        .sdram_we       (sdram_we),
        .rom_byte       (rom_byte)
    );

    // ====================
    // Output side
    // ====================

    // Palette, colour expansion and sync generation
    lcd_to_vga u_lcd_vga (
        .clk_sys     (clk_sys),
        .reset       (reset),
        .lcd_mode    (lcd_mode),
        .lcd_data    (lcd_data),
        .lcd_data_gb (lcd_data_gb),
        .lcd_vsync   (lcd_vsync),
        .is_gbc_game (is_gbc_game),
        .vga_r       (vga_r),
        .vga_g       (vga_g),
        .vga_b       (vga_b),
        .vga_hs      (vga_hs),
        .vga_vs      (vga_vs),
        .vga_hb      (vga_hb),
        .vga_vb      (vga_vb)
    );

endmodule

//--- src/lcd_to_vga.sv
module lcd_to_vga
    import gb_glue_pkg::*;
(
    input  logic                  clk_sys,
    input  logic                  reset,

    // PPU pixel stream
    input  lcd_mode_e             lcd_mode,
    input  logic [rgb555_w-1:0]   lcd_data,
    input  logic [1:0]            lcd_data_gb,
    input  logic                  lcd_vsync,
    input  logic                  is_gbc_game,

    output logic [vga_chan_w-1:0] vga_r,
    output logic [vga_chan_w-1:0] vga_g,
    output logic [vga_chan_w-1:0] vga_b,
    output logic                  vga_hs,
    output logic                  vga_vs,
    output logic                  vga_hb,
    output logic                  vga_vb
);

    // Grey level for monochrome games
    logic [vga_chan_w-1:0] dmg_grey;

    // Mode decode
    logic in_hblank;
    logic in_vblank;

    // Registered mode history for the HSync edge
    logic last_hblank;
    logic hblank_entry;

    // Widen a 5-bit colour field to 8 bits, top bits fill the LSBs
    function automatic logic [vga_chan_w-1:0] expand5(input logic [4:0] field);
        logic [vga_chan_w-1:0] wide;
        wide = {field, field[4:2]};
        return wide;
    endfunction

    // ====================
    // Palette and colour
    // ====================

    always_comb begin
        case (lcd_data_gb)
            2'd0: dmg_grey = shade_white;
            2'd1: dmg_grey = shade_light;
            2'd2: dmg_grey = shade_dark;
            default: dmg_grey = shade_black;
        endcase
    end

    // Colour games use the RGB555 word, others the grey level
    assign vga_r = is_gbc_game ? expand5(lcd_data[14:10]) : dmg_grey;
    assign vga_g = is_gbc_game ? expand5(lcd_data[9:5]) : dmg_grey;
    assign vga_b = is_gbc_game ? expand5(lcd_data[4:0]) : dmg_grey;

    // ====================
    // Blanking
    // ====================

    always_comb begin
        in_hblank = 1'b0;
        in_vblank = 1'b0;
        case (lcd_mode)
            lcd_hblank: in_hblank = 1'b1;
            lcd_vblank: in_vblank = 1'b1;
            // Active line, no blanking
            lcd_oam_scan,
            lcd_pixel_xfer: ;
            default: ;
        endcase
    end

    assign vga_hb = in_hblank;
    assign vga_vb = in_vblank;

    // LCD vsync is active high, VGA wants it low
    assign vga_vs = ~lcd_vsync;

    // ====================
    // HSync pulse
    // ====================

    // First cycle of HBlank after any other mode
    assign hblank_entry = in_hblank & ~last_hblank;

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            last_hblank <= 1'b0;
            vga_hs <= 1'b1;
        end else begin
            last_hblank <= in_hblank;
            // Active low, one cycle wide
            vga_hs <= ~hblank_entry;
        end
    end

endmodule

//--- src/rom_port_mux.sv
module rom_port_mux
    import gb_glue_pkg::*;
(
    // Loader side
    input  logic                    ioctl_download,
    input  logic                    ioctl_wr,
    input  logic [7:0]              ioctl_index,
    input  logic [ioctl_addr_w-1:0] ioctl_addr,
    input  logic [15:0]             ioctl_dout,

    // Cartridge side during play
    input  logic [mbc_addr_w-1:0]   mbc_addr,
    input  logic                    cart_rd,
    input  logic                    cram_rd,

    // Read data back from SDRAM
    input  logic [15:0]             sdram_do,

    output logic                    cart_download,
    output logic [sdram_addr_w-1:0] sdram_addr,
    output logic [15:0]             sdram_di,
    output logic [1:0]              sdram_ds,
    output logic                    sdram_oe,
    output logic                    sdram_we,
    output logic [7:0]              rom_byte
);

    // Index decode for the three cartridge image codes
    logic index_is_cart;

    // Word addresses for each source
    logic [sdram_addr_w-1:0] dl_word_addr;
    logic [sdram_addr_w-1:0] play_word_addr;

    // Byte select inside the 16-bit SDRAM word
    logic byte_hi;

    // ====================
    // Download detection
    // ====================

    assign index_is_cart = (ioctl_index[5:0] == cart_index_low)
                         || (ioctl_index == cart_index_boot)
                         || (ioctl_index == cart_index_alt);

    // Only cartridge images are routed to SDRAM
    assign cart_download = ioctl_download & index_is_cart;

    // ====================
    // Address formation
    // ====================

    // Loader gives a byte address, drop bit 0 for the word
    assign dl_word_addr = ioctl_addr[ioctl_addr_w-1:1];

    // Mapper space sits in the lower half of SDRAM
    assign play_word_addr = {{(sdram_addr_w - mbc_addr_w + 1){1'b0}},
                             mbc_addr[mbc_addr_w-1:1]};

    assign byte_hi = mbc_addr[0];

    // ====================
    // SDRAM request
    // ====================

    always_comb begin
        if (cart_download) begin
            // Whole words written straight from the loader
            sdram_addr = dl_word_addr;
            sdram_di = ioctl_dout;
            sdram_ds = 2'b11;
            sdram_oe = 1'b0;
            sdram_we = ioctl_wr;
        end else begin
            // Byte reads on behalf of the mapper
            sdram_addr = play_word_addr;
            sdram_di = '0;
            sdram_ds = {byte_hi, ~byte_hi};
            // Cart RAM reads are served elsewhere
            sdram_oe = cart_rd & ~cram_rd;
            sdram_we = 1'b0;
        end
    end

    // ====================
    // ROM byte return
    // ====================

    // Odd addresses live in the upper byte lane
    assign rom_byte = byte_hi ? sdram_do[15:8] : sdram_do[7:0];

endmodule

//--- vlog.f
src/gb_glue_pkg.sv
src/clock_enables.sv
src/rom_port_mux.sv
src/lcd_to_vga.sv
src/gb_glue_top.sv
sim/glue_chk.sv
sim/tb_checker.sv
sim/tb_top.sv
